// ==== src/video_config.svh ====
`ifndef VIDEO_CONFIG_SVH
`define VIDEO_CONFIG_SVH

// visible screen
`define LCD_WIDTH 160
`define LCD_LINES 144

// video RAM window on the host bus
`define VRAM_BASE 16'h8000
`define VRAM_BYTES 8192

// background maps, 32x32 tile indices each
`define MAP0_OFFSET 13'h1800
`define MAP1_OFFSET 13'h1c00

// two bytes per row, eight rows
`define TILE_BYTES 16

// register map
`define LCDC_ADDR 16'hff40
`define SCY_ADDR 16'hff42
`define SCX_ADDR 16'hff43
`define LY_ADDR 16'hff44
`define BGP_ADDR 16'hff47

// identity palette, index n gives shade n
`define BGP_RESET 8'he4

`endif

// ==== src/video_types.sv ====
package video_types;

   // grey level driven onto the panel, 0 is the lightest
   typedef logic [1:0] Shade;

   // palette index built from the bit pair of one tile row
   typedef logic [1:0] ColorIndex;

   // byte offset into the 8 KiB video RAM
   typedef logic [12:0] VramAddr;

   typedef logic [7:0] LineNumber;

   // only bgEnable and mapSelect steer the background path,
   // the other bits are kept so the host reads back what it wrote
   typedef struct packed {
      logic [3:0] upperBits;
      logic mapSelect;
      logic [1:0] middleBits;
      logic bgEnable;
   } LcdcReg;

endpackage

// ==== src/videoRam.sv ====
`include "video_config.svh"

module videoRam
(
   input  logic db,
   input  logic enable,
   input  logic write,
   input  video_types::VramAddr addr,
   input  logic [7:0] writeData,
   output logic [7:0] readData
);

   logic [7:0] mem [`VRAM_BYTES];

   // registered read, data appears one cycle after enable
   always_ff @(posedge db)
   begin
      if (enable)
      begin
         if (write)
         begin
            mem[addr] <= writeData;
         end
         readData <= mem[addr];
      end
   end

endmodule

// ==== src/vramArbiter.sv ====
module vramArbiter
(
   input  logic db,
   input  logic reset,
   input  logic hostReq,
   input  logic hostWrite,
   input  video_types::VramAddr hostAddr,
   input  logic [7:0] hostWriteData,
   output logic hostAck,
   output logic [7:0] hostReadData,
   input  logic fetchReq,
   input  video_types::VramAddr fetchAddr,
   output logic fetchAck,
   output logic [7:0] fetchData,
   output logic ramEnable,
   output logic ramWrite,
   output video_types::VramAddr ramAddr,
   output logic [7:0] ramWriteData,
   input  logic [7:0] ramReadData
);

   typedef enum logic {arbIdle, arbAccess} ArbState;

   ArbState state;
   logic lastGrantFetch;
   logic anyReq;
   logic pickHost;

   assign anyReq = hostReq || fetchReq;

   // host wins unless both ask and the fetch port is owed its turn
   assign pickHost = hostReq && (!fetchReq || lastGrantFetch);

   // the access is issued straight from idle, so one is in flight at most
   assign ramEnable = (state == arbIdle) && anyReq;
   assign ramWrite = ramEnable && pickHost && hostWrite;
   assign ramAddr = pickHost ? hostAddr : fetchAddr;
   assign ramWriteData = hostWriteData;

   // ack lands with the RAM output, lastGrantFetch names the owner
   assign hostAck = (state == arbAccess) && !lastGrantFetch;
   assign fetchAck = (state == arbAccess) && lastGrantFetch;
   assign hostReadData = ramReadData;
   assign fetchData = ramReadData;

   always_ff @(posedge db)
   begin
      if (reset)
      begin
         state <= arbIdle;
         // pretend fetch went last so the host gets the first contested grant
         lastGrantFetch <= 1'b1;
      end
      else
      begin
         case (state)
            arbIdle:
            begin
               if (anyReq)
               begin
                  state <= arbAccess;
                  lastGrantFetch <= !pickHost;
               end
            end
            arbAccess:
            begin
               state <= arbIdle;
            end
            default:
            begin
               state <= arbIdle;
            end
         endcase
      end
   end

endmodule

// ==== src/lcdControl.sv ====
`include "video_config.svh"

module lcdControl
(
   input  logic db,
   input  logic reset,
   input  logic [15:0] addr,
   input  logic [7:0] writeData,
   input  logic write,
   input  logic read,
   output logic [7:0] readData,
   output logic readValid,
   output logic busy,
   output logic hostReq,
   output logic hostWrite,
   output video_types::VramAddr hostAddr,
   output logic [7:0] hostWriteData,
   input  logic hostAck,
   input  logic [7:0] hostReadData,
   output video_types::LcdcReg lcdc,
   output logic [7:0] scy,
   output logic [7:0] scx,
   output logic [7:0] bgp,
   input  video_types::LineNumber currentLine
);

   import video_types::*;

   localparam logic [15:0] vramEnd = 16'(`VRAM_BASE + `VRAM_BYTES);

   logic inVram;
   logic [7:0] regValue;

   assign inVram = (addr >= `VRAM_BASE) && (addr < vramEnd);

   // a pending video RAM access is the only thing that stalls the host
   assign busy = hostReq;

   // local read mux, anything not decoded reads as all ones
   always_comb
   begin
      case (addr)
         `LCDC_ADDR: regValue = lcdc;
         `SCY_ADDR: regValue = scy;
         `SCX_ADDR: regValue = scx;
         `LY_ADDR: regValue = currentLine;
         `BGP_ADDR: regValue = bgp;
         default: regValue = 8'hff;
      endcase
   end

   always_ff @(posedge db)
   begin
      if (reset)
      begin
         lcdc <= '0;
         scy <= '0;
         scx <= '0;
         bgp <= `BGP_RESET;
         hostReq <= 1'b0;
         readValid <= 1'b0;
      end
      else
      begin
         readValid <= 1'b0;
         if (hostAck)
         begin
            hostReq <= 1'b0;
            readValid <= !hostWrite;
         end
         else if ((read || write) && inVram)
         begin
            hostReq <= 1'b1;
         end
         else if (read)
         begin
            readValid <= 1'b1;
         end
         else if (write)
         begin
            // LY and unmapped addresses drop the write
            case (addr)
               `LCDC_ADDR: lcdc <= LcdcReg'(writeData);
               `SCY_ADDR: scy <= writeData;
               `SCX_ADDR: scx <= writeData;
               `BGP_ADDR: bgp <= writeData;
               default: ;
            endcase
         end
      end
   end

   always_ff @(posedge db)
   begin
      if ((read || write) && inVram)
      begin
         hostWrite <= write;
         hostAddr <= VramAddr'(addr - `VRAM_BASE);
         hostWriteData <= writeData;
      end
      if (hostAck)
      begin
         readData <= hostReadData;
      end
      else if (read && !inVram)
      begin
         readData <= regValue;
      end
   end

endmodule

// ==== src/lineRenderer.sv ====
`include "video_config.svh"

module lineRenderer
(
   input  logic db,
   input  logic reset,
   input  logic drawLine,
   input  video_types::LcdcReg lcdc,
   input  logic [7:0] scy,
   input  logic [7:0] scx,
   input  logic [7:0] bgp,
   output logic fetchReq,
   output video_types::VramAddr fetchAddr,
   input  logic fetchAck,
   input  logic [7:0] fetchData,
   output video_types::LineNumber currentLine,
   output logic pixelValid,
   output logic [7:0] pixelX,
   output video_types::LineNumber pixelY,
   output video_types::Shade pixelShade,
   output logic lineDone,
   output logic renderComplete
);

   import video_types::*;

   localparam logic [7:0] lastX = 8'(`LCD_WIDTH - 1);
   localparam LineNumber lastLine = LineNumber'(`LCD_LINES - 1);

   typedef enum logic [2:0]
   {
      rIdle,
      rFetchMap,
      rFetchLow,
      rFetchHigh,
      rEmit,
      rFinish
   } RenderState;

   RenderState state;
   logic [7:0] x;
   logic [7:0] lineScx;
   logic [7:0] bgY;
   logic lineEnable;
   logic [7:0] bgX;
   logic [7:0] tileIndex;
   logic [7:0] lowByte;
   logic [7:0] highByte;
   VramAddr mapAddr;
   VramAddr rowAddr;
   logic [2:0] bitSel;
   ColorIndex colorIndex;
   Shade shade;

   // 8-bit adds wrap at 256 the way the background does
   assign bgX = x + lineScx;

   // 32 entries per map row
   assign mapAddr = (lcdc.mapSelect ? `MAP1_OFFSET : `MAP0_OFFSET)
                    + {3'b000, bgY[7:3], bgX[7:3]};
   assign rowAddr = VramAddr'(tileIndex) * VramAddr'(`TILE_BYTES)
                    + {9'd0, bgY[2:0], 1'b0};

   assign fetchReq = (state == rFetchMap) || (state == rFetchLow) || (state == rFetchHigh);

   always_comb
   begin
      case (state)
         rFetchMap: fetchAddr = mapAddr;
         rFetchLow: fetchAddr = rowAddr;
         default: fetchAddr = rowAddr + 13'd1;
      endcase
   end

   // leftmost pixel of a row sits in bit 7
   assign bitSel = 3'd7 - bgX[2:0];
   assign colorIndex = {highByte[bitSel], lowByte[bitSel]};
   assign shade = lineEnable ? bgp[{colorIndex, 1'b0} +: 2] : 2'b00;

   always_ff @(posedge db)
   begin
      if (reset)
      begin
         state <= rIdle;
         x <= '0;
         currentLine <= '0;
         pixelValid <= 1'b0;
         lineDone <= 1'b0;
         renderComplete <= 1'b0;
      end
      else
      begin
         pixelValid <= 1'b0;
         lineDone <= 1'b0;
         renderComplete <= 1'b0;
         case (state)
            rIdle:
            begin
               if (drawLine)
               begin
                  x <= '0;
                  state <= lcdc.bgEnable ? rFetchMap : rEmit;
               end
            end
            rFetchMap:
            begin
               if (fetchAck)
               begin
                  state <= rFetchLow;
               end
            end
            rFetchLow:
            begin
               if (fetchAck)
               begin
                  state <= rFetchHigh;
               end
            end
            rFetchHigh:
            begin
               if (fetchAck)
               begin
                  state <= rEmit;
               end
            end
            rEmit:
            begin
               pixelValid <= 1'b1;
               x <= x + 8'd1;
               if (x == lastX)
               begin
                  state <= rFinish;
               end
               else if (lineEnable && bgX[2:0] == 3'd7)
               begin
                  // next pixel starts a new tile
                  state <= rFetchMap;
               end
            end
            rFinish:
            begin
               lineDone <= 1'b1;
               state <= rIdle;
               if (currentLine == lastLine)
               begin
                  currentLine <= '0;
                  renderComplete <= 1'b1;
               end
               else
               begin
                  currentLine <= currentLine + 8'd1;
               end
            end
            default:
            begin
               state <= rIdle;
            end
         endcase
      end
   end

   always_ff @(posedge db)
   begin
      // scroll and enable are frozen for the whole line
      if (state == rIdle && drawLine)
      begin
         bgY <= currentLine + scy;
         lineScx <= scx;
         lineEnable <= lcdc.bgEnable;
      end
      if (fetchAck)
      begin
         case (state)
            rFetchMap: tileIndex <= fetchData;
            rFetchLow: lowByte <= fetchData;
            default: highByte <= fetchData;
         endcase
      end
      pixelX <= x;
      pixelY <= currentLine;
      pixelShade <= shade;
   end

endmodule

// ==== src/whizGraphics.sv ====
module whizGraphics
(
   input  logic db,
   input  logic reset,
   input  logic [15:0] addr,
   input  logic [7:0] writeData,
   input  logic write,
   input  logic read,
   output logic [7:0] readData,
   output logic readValid,
   output logic busy,
   input  logic drawLine,
   output logic pixelValid,
   output logic [7:0] pixelX,
   output video_types::LineNumber pixelY,
   output video_types::Shade pixelShade,
   output logic lineDone,
   output logic renderComplete
);

   import video_types::*;

   // register file to renderer
   LcdcReg lcdc;
   logic [7:0] scy;
   logic [7:0] scx;
   logic [7:0] bgp;
   LineNumber currentLine;

   // host side of the arbiter
   logic hostReq;
   logic hostWrite;
   VramAddr hostAddr;
   logic [7:0] hostWriteData;
   logic hostAck;
   logic [7:0] hostReadData;

   // fetch side of the arbiter
   logic fetchReq;
   VramAddr fetchAddr;
   logic fetchAck;
   logic [7:0] fetchData;

   // RAM port
   logic ramEnable;
   logic ramWrite;
   VramAddr ramAddr;
   logic [7:0] ramWriteData;
   logic [7:0] ramReadData;

   lcdControl lcdControl_i
   (
      .db(db),
      .reset(reset),
      .addr(addr),
      .writeData(writeData),
      .write(write),
      .read(read),
      .readData(readData),
      .readValid(readValid),
      .busy(busy),
      .hostReq(hostReq),
      .hostWrite(hostWrite),
      .hostAddr(hostAddr),
      .hostWriteData(hostWriteData),
      .hostAck(hostAck),
      .hostReadData(hostReadData),
      .lcdc(lcdc),
      .scy(scy),
      .scx(scx),
      .bgp(bgp),
      .currentLine(currentLine)
   );

   vramArbiter vramArbiter_i
   (
      .db(db),
      .reset(reset),
      .hostReq(hostReq),
      .hostWrite(hostWrite),
      .hostAddr(hostAddr),
      .hostWriteData(hostWriteData),
      .hostAck(hostAck),
      .hostReadData(hostReadData),
      .fetchReq(fetchReq),
      .fetchAddr(fetchAddr),
      .fetchAck(fetchAck),
      .fetchData(fetchData),
      .ramEnable(ramEnable),
      .ramWrite(ramWrite),
      .ramAddr(ramAddr),
      .ramWriteData(ramWriteData),
      .ramReadData(ramReadData)
   );

   videoRam videoRam_i
   (
      .db(db),
      .enable(ramEnable),
      .write(ramWrite),
      .addr(ramAddr),
      .writeData(ramWriteData),
      .readData(ramReadData)
   );

   lineRenderer lineRenderer_i
   (
      .db(db),
      .reset(reset),
      .drawLine(drawLine),
      .lcdc(lcdc),
      .scy(scy),
      .scx(scx),
      .bgp(bgp),
      .fetchReq(fetchReq),
      .fetchAddr(fetchAddr),
      .fetchAck(fetchAck),
      .fetchData(fetchData),
      .currentLine(currentLine),
      .pixelValid(pixelValid),
      .pixelX(pixelX),
      .pixelY(pixelY),
      .pixelShade(pixelShade),
      .lineDone(lineDone),
      .renderComplete(renderComplete)
   );

endmodule

// ==== verification/vramArbiter_properties.sv ====
module vramArbiterProperties
(
   input logic db,
   input logic reset,
   input logic hostReq,
   input logic hostAck,
   input logic fetchReq,
   input logic fetchAck,
   input logic ramEnable
);

   // one RAM access in flight, so one ack at a time
   assert property (@(posedge db) disable iff (reset) !(hostAck && fetchAck))
      else $error("hostAck and fetchAck high together");

   assert property (@(posedge db) disable iff (reset) hostAck |-> hostReq)
      else $error("hostAck without hostReq");

   assert property (@(posedge db) disable iff (reset) fetchAck |-> fetchReq)
      else $error("fetchAck without fetchReq");

   // requests stay up until served
   assert property (@(posedge db) disable iff (reset) hostReq && !hostAck |=> hostReq)
      else $error("hostReq dropped before hostAck");

   assert property (@(posedge db) disable iff (reset) fetchReq && !fetchAck |=> fetchReq)
      else $error("fetchReq dropped before fetchAck");

   assert property (@(posedge db) reset |=> !ramEnable)
      else $error("ramEnable high right after reset");

endmodule

bind vramArbiter vramArbiterProperties vramArbiterProperties_i
(
   .db(db),
   .reset(reset),
   .hostReq(hostReq),
   .hostAck(hostAck),
   .fetchReq(fetchReq),
   .fetchAck(fetchAck),
   .ramEnable(ramEnable)
);

// ==== verification/whizGraphicsTb.sv ====
`include "video_config.svh"

module whizGraphicsTb;

   import video_types::*;

   // generous per-item budgets, in clock cycles
   localparam int busOpCycles = 12;
   localparam int lineCycles = 700;
   localparam int busOps = `VRAM_BYTES + 400;
   localparam int lineCount = 160;
   localparam int watchdogCycles = busOps * busOpCycles + lineCount * lineCycles;

   logic db;
   logic reset;
   logic [15:0] addr;
   logic [7:0] writeData;
   logic write;
   logic read;
   logic [7:0] readData;
   logic readValid;
   logic busy;
   logic drawLine;
   logic pixelValid;
   logic [7:0] pixelX;
   LineNumber pixelY;
   Shade pixelShade;
   logic lineDone;
   logic renderComplete;

   // model of the video RAM and registers
   logic [7:0] shadowVram [`VRAM_BYTES];
   logic [7:0] shadowLcdc;
   logic [7:0] shadowScx;
   logic [7:0] shadowScy;
   logic [7:0] shadowBgp;
   int modelLine;
   int readCycles;
   int errorCount;
   integer seed;

   whizGraphics dut_i
   (
      .db(db),
      .reset(reset),
      .addr(addr),
      .writeData(writeData),
      .write(write),
      .read(read),
      .readData(readData),
      .readValid(readValid),
      .busy(busy),
      .drawLine(drawLine),
      .pixelValid(pixelValid),
      .pixelX(pixelX),
      .pixelY(pixelY),
      .pixelShade(pixelShade),
      .lineDone(lineDone),
      .renderComplete(renderComplete)
   );

   initial
   begin
      db = 1'b0;
      forever #50 db = ~db;
   end

   initial
   begin
      repeat (watchdogCycles) @(posedge db);
      abortRun("simulation ran past its time limit");
   end

   task automatic abortRun(input string reason);
      $display("%s", reason);
      $display("Test failures found");
      $fatal(1);
   endtask

   task automatic checkValue(input string name, input logic [15:0] actual,
                             input logic [15:0] expected);
      if (actual !== expected)
      begin
         errorCount++;
         $display("** Error at time %0t: %s is %0h, expected %0h",
                  $time, name, actual, expected);
         abortRun("value mismatch");
      end
   endtask

   task automatic waitIdle();
      int n;
      n = 0;
      while (busy)
      begin
         @(posedge db);
         n++;
         if (n > 1000)
         begin
            abortRun("host bus stayed busy for too long");
         end
      end
   endtask

   task automatic busWrite(input logic [15:0] a, input logic [7:0] d);
      waitIdle();
      addr <= a;
      writeData <= d;
      write <= 1'b1;
      @(posedge db);
      write <= 1'b0;
      @(posedge db);
      waitIdle();
   endtask

   task automatic busRead(input logic [15:0] a, output logic [7:0] d);
      int n;
      waitIdle();
      addr <= a;
      read <= 1'b1;
      @(posedge db);
      read <= 1'b0;
      n = 0;
      do
      begin
         @(posedge db);
         n++;
         if (n > 1000)
         begin
            abortRun("read never returned readValid");
         end
      end
      while (!readValid);
      readCycles = n;
      d = readData;
   endtask

   task automatic vramWrite(input logic [12:0] offset, input logic [7:0] d);
      busWrite(16'(`VRAM_BASE + int'(offset)), d);
      shadowVram[offset] = d;
   endtask

   task automatic vramCheck(input logic [12:0] offset);
      logic [7:0] d;
      busRead(16'(`VRAM_BASE + int'(offset)), d);
      checkValue("vram readData", 16'(d), 16'(shadowVram[offset]));
   endtask

   task automatic regWrite(input logic [15:0] a, input logic [7:0] d);
      busWrite(a, d);
      case (a)
         `LCDC_ADDR: shadowLcdc = d;
         `SCX_ADDR: shadowScx = d;
         `SCY_ADDR: shadowScy = d;
         `BGP_ADDR: shadowBgp = d;
         default: ;
      endcase
   endtask

   task automatic regCheck(input string name, input logic [15:0] a,
                           input logic [7:0] expected);
      logic [7:0] d;
      busRead(a, d);
      checkValue(name, 16'(d), 16'(expected));
      checkValue("register read latency", 16'(readCycles), 16'd1);
   endtask

   // background shade for pixel px of the model's current line
   function automatic logic [1:0] expectedShade(input int px);
      int bgX;
      int bgY;
      int mapBase;
      logic [12:0] mapAddr;
      logic [7:0] tileIndex;
      logic [12:0] rowAddr;
      logic [2:0] bitPos;
      logic [1:0] ci;
      if (!shadowLcdc[0])
      begin
         return 2'b00;
      end
      bgX = (px + int'(shadowScx)) % 256;
      bgY = (modelLine + int'(shadowScy)) % 256;
      mapBase = shadowLcdc[3] ? int'(`MAP1_OFFSET) : int'(`MAP0_OFFSET);
      mapAddr = 13'(mapBase + (bgY / 8) * 32 + bgX / 8);
      tileIndex = shadowVram[mapAddr];
      rowAddr = 13'(int'(tileIndex) * `TILE_BYTES + 2 * (bgY % 8));
      bitPos = 3'(7 - bgX % 8);
      ci = {shadowVram[rowAddr + 13'd1][bitPos], shadowVram[rowAddr][bitPos]};
      return shadowBgp[2 * int'(ci) +: 2];
   endfunction

   task automatic renderLine();
      int x;
      int n;
      logic done;
      drawLine <= 1'b1;
      @(posedge db);
      drawLine <= 1'b0;
      x = 0;
      n = 0;
      done = 1'b0;
      while (!done)
      begin
         @(posedge db);
         n++;
         if (n > lineCycles)
         begin
            abortRun("line render did not finish");
         end
         if (pixelValid)
         begin
            checkValue("pixelX", 16'(pixelX), 16'(x));
            checkValue("pixelY", 16'(pixelY), 16'(modelLine));
            checkValue("pixelShade", 16'(pixelShade), 16'(expectedShade(x)));
            x++;
         end
         // frame end comes only with the lineDone of the last line
         checkValue("renderComplete", 16'(renderComplete),
                    16'(lineDone && modelLine == `LCD_LINES - 1));
         done = lineDone;
      end
      checkValue("pixel count", 16'(x), 16'(`LCD_WIDTH));
      modelLine = (modelLine + 1) % `LCD_LINES;
   endtask

   task automatic fillMemory();
      for (int i = 0; i < `VRAM_BYTES; i++)
      begin
         vramWrite(13'(i), 8'($random(seed)));
      end
   endtask

   task automatic resetAndRegisters();
      regCheck("LCDC", `LCDC_ADDR, 8'h00);
      regCheck("SCX", `SCX_ADDR, 8'h00);
      regCheck("SCY", `SCY_ADDR, 8'h00);
      regCheck("LY", `LY_ADDR, 8'h00);
      regCheck("BGP", `BGP_ADDR, `BGP_RESET);
      regCheck("unmapped ff41", 16'hff41, 8'hff);
      regCheck("unmapped 1234", 16'h1234, 8'hff);
      regWrite(`LCDC_ADDR, 8'hf2);
      regWrite(`SCX_ADDR, 8'(($random(seed))));
      regWrite(`SCY_ADDR, 8'(($random(seed))));
      regWrite(`BGP_ADDR, 8'h1b);
      busWrite(16'hff41, 8'h55);
      regCheck("LCDC", `LCDC_ADDR, shadowLcdc);
      regCheck("SCX", `SCX_ADDR, shadowScx);
      regCheck("SCY", `SCY_ADDR, shadowScy);
      regCheck("BGP", `BGP_ADDR, shadowBgp);
      regCheck("unmapped ff41", 16'hff41, 8'hff);
      // LY is read-only
      busWrite(`LY_ADDR, 8'h77);
      regCheck("LY", `LY_ADDR, 8'h00);
   endtask

   task automatic vramReadback();
      logic [12:0] offsets [48];
      for (int i = 0; i < 48; i++)
      begin
         // thirds land in tiles, map 0 and map 1
         case (i % 3)
            0: offsets[i] = 13'($unsigned($random(seed)) % 32'h1800);
            1: offsets[i] = `MAP0_OFFSET + 13'($random(seed) & 32'h3ff);
            default: offsets[i] = `MAP1_OFFSET + 13'($random(seed) & 32'h3ff);
         endcase
         vramWrite(offsets[i], 8'($random(seed)));
      end
      for (int i = 0; i < 48; i++)
      begin
         vramCheck(offsets[i]);
      end
   endtask

   task automatic unscrolledLine();
      fillMemory();
      regWrite(`SCX_ADDR, 8'h00);
      regWrite(`SCY_ADDR, 8'h00);
      regWrite(`BGP_ADDR, `BGP_RESET);
      regWrite(`LCDC_ADDR, 8'h01);
      repeat (3) renderLine();
   endtask

   task automatic scrollMapPalette();
      // large scroll values so both axes wrap at 256
      regWrite(`SCX_ADDR, 8'hc0 | 8'($random(seed)));
      regWrite(`SCY_ADDR, 8'hfe | 8'($random(seed)));
      regWrite(`BGP_ADDR, 8'($random(seed)));
      regWrite(`LCDC_ADDR, 8'h09);
      repeat (2) renderLine();
      regWrite(`LCDC_ADDR, 8'h08);
      renderLine();
   endtask

   task automatic fullFrame();
      logic [7:0] d;
      regWrite(`SCX_ADDR, 8'h05);
      regWrite(`SCY_ADDR, 8'h00);
      regWrite(`LCDC_ADDR, 8'h01);
      do
      begin
         renderLine();
      end
      while (modelLine != 0);
      busRead(`LY_ADDR, d);
      checkValue("LY after frame", 16'(d), 16'h0000);
   endtask

   task automatic hostDuringRender();
      logic [12:0] mapOffset;
      regWrite(`LCDC_ADDR, 8'h01);
      fork
         renderLine();
         begin
            // map 1 is not selected, so these writes leave the line unchanged
            for (int i = 0; i < 6; i++)
            begin
               mapOffset = `MAP1_OFFSET + 13'($random(seed) & 32'h3ff);
               vramWrite(mapOffset, 8'($random(seed)));
               vramCheck(mapOffset);
               vramCheck(13'($unsigned($random(seed)) % 32'h1800));
            end
         end
      join
   endtask

   initial
   begin
      seed = 32'hdd28c62b;
      errorCount = 0;
      modelLine = 0;
      shadowLcdc = 8'h00;
      shadowScx = 8'h00;
      shadowScy = 8'h00;
      shadowBgp = `BGP_RESET;
      reset = 1'b1;
      addr = '0;
      writeData = '0;
      write = 1'b0;
      read = 1'b0;
      drawLine = 1'b0;
      repeat (5) @(posedge db);
      reset <= 1'b0;
      @(posedge db);
      resetAndRegisters();
      vramReadback();
      unscrolledLine();
      scrollMapPalette();
      fullFrame();
      hostDuringRender();
      if (errorCount == 0)
      begin
         $display("All tests passed!");
         $finish;
      end
      else
      begin
         abortRun("checks failed");
      end
   end

endmodule

// ==== all.f ====
+incdir+src
src/video_types.sv
src/videoRam.sv
src/vramArbiter.sv
src/lcdControl.sv
src/lineRenderer.sv
src/whizGraphics.sv
verification/vramArbiter_properties.sv
verification/whizGraphicsTb.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only -Wall --timing
TOP = whizGraphicsTb
FILELIST = all.f
BUILD_DIR = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
